// ==== sim.f ====
hdl/bls12_381_pkg.sv
hdl/fe2_mul.sv
hdl/fe6_fmap.sv
hdl/fe12_fmap.sv
hdl/fmap_regs.sv
hdl/fmap_top.sv
verif/fmap_chk.sv
verif/fmap_tb.sv

// ==== verif/fmap_tb.sv ====
// --------------------
// Frobenius map testbench
// Directed tests over APB and the element stream,
// checked against a software Fp12 Frobenius model
// --------------------
`default_nettype none

module fmap_tb
  import bls12_381_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_PER_K     = 2;              // Elements per power in the power test
  localparam int N_STALL     = 4;
  localparam int N_COUNT     = 3;
  localparam int TOTAL_ELEMS = 1 + 3 * N_PER_K + N_STALL + N_COUNT;
  localparam int MAX_BEATS   = 12 * N_STALL;   // Largest burst
  localparam int WDOG_CYCLES = TOTAL_ELEMS * 2000 + 5000;

  logic        i_clk, i_rst;
  logic        i_psel, i_penable, i_pwrite;
  logic [7:0]  i_paddr;
  logic [31:0] i_pwdata;
  logic [31:0] o_prdata;
  logic        o_pready, o_pslverr;
  logic        i_s_val, o_s_rdy, i_s_sop, i_s_eop;
  fe_t         i_s_dat;
  logic        o_m_val, i_m_rdy, o_m_sop, o_m_eop;
  fe_t         o_m_dat;

  integer seed = 32'h421b_c7c5;
  fe_t    stim_mem [0:MAX_BEATS-1];            // Input beats of the current burst
  fe_t    exp_mem  [0:MAX_BEATS-1];            // Expected output beats
  logic   stall_en;                            // Random back-pressure on o_m
  int     elem_total;

  fmap_top #(
    .ADDR_W (8)
  ) i_fmap_top (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_psel (i_psel), .i_penable (i_penable), .i_pwrite (i_pwrite),
    .i_paddr (i_paddr), .i_pwdata (i_pwdata), .o_prdata (o_prdata),
    .o_pready (o_pready), .o_pslverr (o_pslverr),
    .i_s_val (i_s_val), .o_s_rdy (o_s_rdy), .i_s_sop (i_s_sop), .i_s_eop (i_s_eop),
    .i_s_dat (i_s_dat),
    .o_m_val (o_m_val), .i_m_rdy (i_m_rdy), .o_m_sop (o_m_sop), .o_m_eop (o_m_eop),
    .o_m_dat (o_m_dat)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;                 // 4 ns period
  end

  // Field arithmetic for the model
  function automatic fe_t fp_add(input fe_t a, input fe_t b);
    logic [381:0] s;
    s = {1'b0, a} + b;
    if (s >= P) s = s - P;
    return s[380:0];
  endfunction

  function automatic fe_t fp_neg(input fe_t a);
    return (a == '0) ? fe_t'(0) : P - a;
  endfunction

  // Shift and add over the bits of b
  function automatic fe_t fp_mul(input fe_t a, input fe_t b);
    logic [381:0] r;
    int           i;
    r = '0;
    for (i = 380; i >= 0; i--) begin
      r = r << 1;
      if (r >= P) r = r - P;
      if (b[i]) begin
        r = r + a;
        if (r >= P) r = r - P;
      end
    end
    return r[380:0];
  endfunction

  function automatic fe_t fp2_re(input fe_t a0, input fe_t a1, input fe_t b0, input fe_t b1);
    return fp_add(fp_mul(a0, b0), fp_neg(fp_mul(a1, b1)));   // u^2 = -1
  endfunction

  function automatic fe_t fp2_im(input fe_t a0, input fe_t a1, input fe_t b0, input fe_t b1);
    return fp_add(fp_mul(a0, b1), fp_mul(a1, b0));
  endfunction

  function automatic fe_t rand_fe();
    logic [383:0] r;
    int           i;
    r = '0;
    for (i = 0; i < 12; i++) r = {r[351:0], 32'($random(seed))};
    return fe_t'(r % P);
  endfunction

  // Frobenius x^(p^k) of the element at stim_mem[base]
  function automatic void ref_frobenius(input int base, input int k);
    fe_t re, im, t;
    int  h, j, idx;
    for (h = 0; h < 2; h++) begin
      for (j = 0; j < 3; j++) begin
        idx = base + 6 * h + 2 * j;
        re  = stim_mem[idx];
        im  = stim_mem[idx + 1];
        if (k % 2 == 1) im = fp_neg(im);       // Conjugate
        if (j == 1) begin
          t  = fp2_re(re, im, FROBENIUS_COEFF_FQ6_C1[k][0], FROBENIUS_COEFF_FQ6_C1[k][1]);
          im = fp2_im(re, im, FROBENIUS_COEFF_FQ6_C1[k][0], FROBENIUS_COEFF_FQ6_C1[k][1]);
          re = t;
        end else if (j == 2) begin
          t  = fp2_re(re, im, FROBENIUS_COEFF_FQ6_C2[k][0], FROBENIUS_COEFF_FQ6_C2[k][1]);
          im = fp2_im(re, im, FROBENIUS_COEFF_FQ6_C2[k][0], FROBENIUS_COEFF_FQ6_C2[k][1]);
          re = t;
        end
        if (h == 1) begin                      // Fp12 scale of the c1 half
          t  = fp2_re(re, im, FROBENIUS_COEFF_FQ12_C1[k][0], FROBENIUS_COEFF_FQ12_C1[k][1]);
          im = fp2_im(re, im, FROBENIUS_COEFF_FQ12_C1[k][0], FROBENIUS_COEFF_FQ12_C1[k][1]);
          re = t;
        end
        exp_mem[idx]     = re;
        exp_mem[idx + 1] = im;
      end
    end
  endfunction

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1, "Stopping at the first error");
  endtask

  task automatic check_fe(input fe_t got, input fe_t exp, input int beat);
    if (got !== exp) begin
      $display("CHECK FAILED at %0.1f ns: data on beat %0d is %h, expected %h",
               $realtime, beat, got, exp);
      fail_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0.1f ns: %s is %b, expected %b", $realtime, what, got, exp);
      fail_run();
    end
  endtask

  task automatic check_reg(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at %0.1f ns: %s reads %h, expected %h", $realtime, what, got, exp);
      fail_run();
    end
  endtask

  // One APB transfer that starts and ends 1 ns after a rising edge
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waits;
    i_psel    = 1'b1;                          // Setup phase
    i_penable = 1'b0;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = wdata;
    @(posedge i_clk);
    #1 i_penable = 1'b1;                       // Access phase
    waits = 0;
    @(negedge i_clk);
    while (!o_pready) begin
      waits++;
      if (waits > 16) begin
        $display("APB access to address %h never completed", addr);
        fail_run();
      end
      @(negedge i_clk);
    end
    rdata = o_prdata;
    err   = o_pslverr;
    @(posedge i_clk);
    #1;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    apb_access(1'b0, addr, 32'h0, data, err);
  endtask

  task automatic set_power(input int k);
    logic err;
    apb_write(REG_POWER, 32'(k), err);
    check_flag(err, 1'b0, "pslverr on POWER write");
  endtask

  // Twelve beats with val and data held until each transfer
  task automatic send_fe12(input int base);
    int   i;
    logic taken;
    for (i = 0; i < 12; i++) begin
      i_s_val = 1'b1;
      i_s_sop = (i == 0);
      i_s_eop = (i == 11);
      i_s_dat = stim_mem[base + i];
      taken   = 1'b0;
      while (!taken) begin
        @(negedge i_clk);
        taken = o_s_rdy;
        @(posedge i_clk);
        #1;
      end
    end
    i_s_val = 1'b0;
    i_s_sop = 1'b0;
    i_s_eop = 1'b0;
  endtask

  task automatic recv_fe12(input int base);
    int beat;
    beat = 0;
    while (beat < 12) begin
      i_m_rdy = stall_en ? (($random(seed) & 3) != 0) : 1'b1;   // About 1 stall in 4
      @(negedge i_clk);
      if (o_m_val && i_m_rdy) begin
        check_fe(o_m_dat, exp_mem[base + beat], base + beat);
        check_flag(o_m_sop, beat == 0, $sformatf("sop on beat %0d", beat));
        check_flag(o_m_eop, beat == 11, $sformatf("eop on beat %0d", beat));
        beat++;
      end
      @(posedge i_clk);
      #1;
    end
  endtask

  task automatic send_burst(input int n);
    int e;
    for (e = 0; e < n; e++) send_fe12(12 * e);  // Back to back
  endtask

  task automatic recv_burst(input int n);
    int e;
    for (e = 0; e < n; e++) recv_fe12(12 * e);
    i_m_rdy = 1'b0;
  endtask

  // Output must stay quiet once all beats are in
  task automatic check_idle();
    i_m_rdy = 1'b1;
    repeat (40) begin
      @(negedge i_clk);
      check_flag(o_m_val, 1'b0, "o_m_val after the last expected beat");
    end
    @(posedge i_clk);
    #1;
  endtask

  task automatic run_elements(input int n, input int k, input logic stall, input logic special);
    int e, i;
    for (e = 0; e < n; e++) begin
      for (i = 0; i < 12; i++) begin
        if (special && e == 0)
          stim_mem[12 * e + i] = (i % 3 == 0) ? fe_t'(0) : (i % 3 == 1) ? P - 1 : fe_t'(i);
        else
          stim_mem[12 * e + i] = rand_fe();
      end
      if (k == 0) begin
        for (i = 0; i < 12; i++) exp_mem[12 * e + i] = stim_mem[12 * e + i];
      end else begin
        ref_frobenius(12 * e, k);
      end
    end
    stall_en = stall;
    fork
      send_burst(n);
      recv_burst(n);
    join
    elem_total += n;
    check_idle();
  endtask

  task automatic test_reg_access();
    logic [31:0] rd;
    logic        err;
    apb_read(REG_STATUS, rd, err);
    check_reg(rd, 32'h0, "STATUS after reset");
    check_flag(err, 1'b0, "pslverr on STATUS read");
    apb_read(REG_COUNT, rd, err);
    check_reg(rd, 32'h0, "COUNT after reset");
    apb_read(REG_POWER, rd, err);
    check_reg(rd, 32'h0, "POWER after reset");
    set_power(2);
    apb_read(REG_POWER, rd, err);
    check_reg(rd, 32'h2, "POWER after write of 2");
    set_power(1);
    apb_read(REG_POWER, rd, err);
    check_reg(rd, 32'h1, "POWER after write of 1");
    apb_read(8'h0c, rd, err);                  // Unmapped read
    check_flag(err, 1'b1, "pslverr on unmapped read");
    apb_write(8'h10, 32'h3, err);
    check_flag(err, 1'b1, "pslverr on unmapped write");
    apb_read(REG_POWER, rd, err);
    check_reg(rd, 32'h1, "POWER after unmapped write");
  endtask

  task automatic test_identity();
    set_power(0);
    run_elements(1, 0, 1'b0, 1'b0);
  endtask

  task automatic test_powers();
    int k;
    for (k = 1; k <= 3; k++) begin
      set_power(k);
      run_elements(N_PER_K, k, 1'b0, k == 1);  // Zero and P-1 beats for k = 1
    end
  endtask

  task automatic test_stall();
    set_power(1);
    run_elements(N_STALL, 1, 1'b1, 1'b0);
  endtask

  task automatic test_count();
    logic [31:0] rd;
    logic        err;
    set_power(2);
    run_elements(N_COUNT, 2, 1'b0, 1'b0);
    apb_read(REG_COUNT, rd, err);
    check_reg(rd, 32'(elem_total), "COUNT after all elements");
    apb_read(REG_STATUS, rd, err);
    check_reg(rd, 32'h0, "STATUS after the last eop");
  endtask

  initial begin
    i_rst         = 1'b1;
    i_psel        = 1'b0;
    i_penable     = 1'b0;
    i_pwrite      = 1'b0;
    i_paddr       = '0;
    i_pwdata      = '0;
    i_s_val       = 1'b0;
    i_s_sop       = 1'b0;
    i_s_eop       = 1'b0;
    i_s_dat       = '0;
    i_m_rdy       = 1'b0;
    stall_en      = 1'b0;
    elem_total    = 0;
    repeat (16) @(posedge i_clk);
    #1 i_rst = 1'b0;
    test_reg_access();
    test_identity();
    test_powers();
    test_stall();
    test_count();
    $display("Simulation passed");
    $finish;
  end

  // Failures of the bound handshake and framing assertions
  initial begin
    wait (i_fmap_top.u_chk.fail_cnt != 0);
    $display("A bound assertion on the stream or APB handshake failed at %0.1f ns", $realtime);
    fail_run();
  end

  // Watchdog
  initial begin
    repeat (WDOG_CYCLES) @(posedge i_clk);
    $display("Timeout: the tests did not finish within %0d cycles", WDOG_CYCLES);
    fail_run();
  end

endmodule

`default_nettype wire

// ==== verif/fmap_chk.sv ====
// --------------------
// Frobenius map checker
// Stream hold, element framing and APB ready
// --------------------
`default_nettype none

module fmap_chk
  import bls12_381_pkg::*;
(
  input wire i_clk,
  input wire i_rst,
  input wire i_psel,
  input wire i_penable,
  input wire o_pready,
  input wire i_s_val,
  input wire o_s_rdy,
  input wire i_s_sop,
  input wire i_s_eop,
  input fe_t i_s_dat,
  input wire o_m_val,
  input wire i_m_rdy,
  input wire o_m_sop,
  input wire o_m_eop,
  input fe_t o_m_dat
);
  timeunit 1ns;
  timeprecision 100ps;

  logic       out_xfer;
  logic [3:0] out_idx, cur_idx;                // Output beat within the element
  int         fail_cnt = 0;                    // Assertion failures so far

  always_comb begin
    out_xfer = o_m_val && i_m_rdy;
    cur_idx  = o_m_sop ? 4'd0 : out_idx;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) out_idx <= '0;
    else if (out_xfer) out_idx <= o_m_eop ? 4'd0 : cur_idx + 4'd1;
  end

  a_out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_m_val && !i_m_rdy |=> o_m_val && $stable(o_m_dat) && $stable(o_m_sop) && $stable(o_m_eop))
    else begin
      fail_cnt++;
      $error("o_m beat changed or dropped before it was taken");
    end

  a_in_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_s_val && !o_s_rdy |=> i_s_val && $stable(i_s_dat) && $stable(i_s_sop) && $stable(i_s_eop))
    else begin
      fail_cnt++;
      $error("i_s beat changed or dropped before it was taken");
    end

  a_sop_fresh: assert property (@(posedge i_clk) disable iff (i_rst)
    out_xfer && o_m_sop |-> out_idx == 4'd0)
    else begin
      fail_cnt++;
      $error("o_m_sop inside an unfinished element");
    end

  a_eop_at_12: assert property (@(posedge i_clk) disable iff (i_rst)
    out_xfer |-> (o_m_eop ? cur_idx == 4'd11 : cur_idx < 4'd11))
    else begin
      fail_cnt++;
      $error("o_m_eop not on the twelfth beat after sop");
    end

  a_pready: assert property (@(posedge i_clk) disable iff (i_rst)
    i_psel && i_penable |-> o_pready)
    else begin
      fail_cnt++;
      $error("pready low during an APB access phase");
    end

endmodule

bind fmap_top fmap_chk u_chk (
  .i_clk (i_clk), .i_rst (i_rst),
  .i_psel (i_psel), .i_penable (i_penable), .o_pready (o_pready),
  .i_s_val (i_s_val), .o_s_rdy (o_s_rdy), .i_s_sop (i_s_sop), .i_s_eop (i_s_eop),
  .i_s_dat (i_s_dat),
  .o_m_val (o_m_val), .i_m_rdy (i_m_rdy), .o_m_sop (o_m_sop), .o_m_eop (o_m_eop),
  .o_m_dat (o_m_dat)
);

`default_nettype wire

// ==== hdl/fmap_top.sv ====
// --------------------
// Fp12 Frobenius map top level
// Register block, Fp12 and Fp6 stages, outer Fp2 multiplier
// --------------------
`default_nettype none

module fmap_top
  import bls12_381_pkg::*;
#(
  parameter int ADDR_W = 8
)(
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire              i_psel,
  input  wire              i_penable,
  input  wire              i_pwrite,
  input  wire [ADDR_W-1:0] i_paddr,
  input  wire [31:0]       i_pwdata,
  output logic [31:0]      o_prdata,
  output logic             o_pready,
  output logic             o_pslverr,
  input  wire              i_s_val,
  output logic             o_s_rdy,
  input  wire              i_s_sop,
  input  wire              i_s_eop,
  input  fe_t              i_s_dat,
  output logic             o_m_val,
  input  wire              i_m_rdy,
  output logic             o_m_sop,
  output logic             o_m_eop,
  output fe_t              o_m_dat
);

  logic [POW_W-1:0] pow;
  // Fp6 link
  logic f6i_val, f6i_rdy, f6i_sop, f6i_eop;
  fe_t  f6i_dat;
  logic [POW_W-1:0] f6i_pow;
  logic f6o_val, f6o_rdy, f6o_sop, f6o_eop;
  fe_t  f6o_dat;
  logic [POW_W-1:0] f6o_pow;
  // Outer multiplier link
  logic mi_val, mi_rdy, mi_sop, mi_eop;
  fe2_pair_t mi_dat;
  logic [POW_W-1:0] mi_pow;
  logic mo_val, mo_rdy, mo_sop, mo_eop;
  fe_t  mo_dat;

  // Completion pulses for the register block
  wire in_sop  = i_s_val && o_s_rdy && i_s_sop;
  wire out_eop = o_m_val && i_m_rdy && o_m_eop;

  fmap_regs #(
    .ADDR_W (ADDR_W)
  ) u_regs (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_psel (i_psel), .i_penable (i_penable), .i_pwrite (i_pwrite),
    .i_paddr (i_paddr), .i_pwdata (i_pwdata), .o_prdata (o_prdata),
    .o_pready (o_pready), .o_pslverr (o_pslverr),
    .i_in_sop (in_sop), .i_out_eop (out_eop), .o_pow (pow)
  );

  fe12_fmap u_fe12 (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_val (i_s_val), .o_rdy (o_s_rdy), .i_sop (i_s_sop), .i_eop (i_s_eop),
    .i_dat (i_s_dat), .i_pow (pow),
    .o_val (o_m_val), .i_rdy (i_m_rdy), .o_sop (o_m_sop), .o_eop (o_m_eop),
    .o_dat (o_m_dat),
    .o_f6_val (f6i_val), .i_f6_rdy (f6i_rdy), .o_f6_sop (f6i_sop),
    .o_f6_eop (f6i_eop), .o_f6_dat (f6i_dat), .o_f6_pow (f6i_pow),
    .i_f6_val (f6o_val), .o_f6_rdy (f6o_rdy), .i_f6_sop (f6o_sop),
    .i_f6_eop (f6o_eop), .i_f6_dat (f6o_dat), .i_f6_pow (f6o_pow),
    .o_mul_val (mi_val), .i_mul_rdy (mi_rdy), .o_mul_sop (mi_sop),
    .o_mul_eop (mi_eop), .o_mul_dat (mi_dat), .o_mul_pow (mi_pow),
    .i_mul_val (mo_val), .o_mul_rdy (mo_rdy), .i_mul_sop (mo_sop),
    .i_mul_eop (mo_eop), .i_mul_dat (mo_dat)
  );

  fe6_fmap u_fe6 (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_val (f6i_val), .o_rdy (f6i_rdy), .i_sop (f6i_sop), .i_eop (f6i_eop),
    .i_dat (f6i_dat), .i_pow (f6i_pow),
    .o_val (f6o_val), .i_rdy (f6o_rdy), .o_sop (f6o_sop), .o_eop (f6o_eop),
    .o_dat (f6o_dat), .o_pow (f6o_pow)
  );

  // Outer multiplier, power is not needed past this point
  fe2_mul #(
    .FE_TYPE (fe_t)
  ) u_mul (
    .i_clk (i_clk), .i_rst (i_rst),
    .i_val (mi_val), .o_rdy (mi_rdy), .i_sop (mi_sop), .i_eop (mi_eop),
    .i_dat (mi_dat), .i_pow (mi_pow),
    .o_val (mo_val), .i_rdy (mo_rdy), .o_sop (mo_sop), .o_eop (mo_eop),
    .o_dat (mo_dat), .o_pow ()
  );

endmodule

`default_nettype wire

// ==== hdl/fmap_regs.sv ====
// --------------------
// Frobenius register block
// APB access to power, busy status and completion count
// --------------------
`default_nettype none

module fmap_regs
  import bls12_381_pkg::*;
#(
  parameter int ADDR_W = 8
)(
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire              i_psel,
  input  wire              i_penable,
  input  wire              i_pwrite,
  input  wire [ADDR_W-1:0] i_paddr,
  input  wire [31:0]       i_pwdata,
  output logic [31:0]      o_prdata,
  output logic             o_pready,
  output logic             o_pslverr,
  input  wire              i_in_sop,    // Element accepted at input
  input  wire              i_out_eop,   // Element finished at output
  output logic [POW_W-1:0] o_pow
);

  logic        access;
  logic        sel_power, sel_status, sel_count;
  logic [7:0]  in_flight;               // Elements between sop and eop
  logic [31:0] done_cnt;

  always_comb begin
    access     = i_psel && i_penable;   // Access phase
    sel_power  = i_paddr == REG_POWER[ADDR_W-1:0];
    sel_status = i_paddr == REG_STATUS[ADDR_W-1:0];
    sel_count  = i_paddr == REG_COUNT[ADDR_W-1:0];
    o_pready   = 1'b1;                  // No wait states
    o_pslverr  = access && !(sel_power || sel_status || sel_count);
    o_prdata   = '0;
    if (sel_power)  o_prdata[POW_W-1:0] = o_pow;
    if (sel_status) o_prdata[0] = in_flight != '0;  // Busy
    if (sel_count)  o_prdata = done_cnt;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_pow     <= '0;
      in_flight <= '0;
      done_cnt  <= '0;
    end else begin
      if (access && i_pwrite && sel_power) o_pow <= i_pwdata[POW_W-1:0];
      case ({i_in_sop, i_out_eop})
        2'b10:   in_flight <= in_flight + 8'd1;
        2'b01:   in_flight <= in_flight - 8'd1;
        default: in_flight <= in_flight;  // Start and finish cancel
      endcase
      if (i_out_eop) done_cnt <= done_cnt + 32'd1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fe12_fmap.sv ====
// --------------------
// Fp12 Frobenius stage
// Routes beats through the Fp6 stage, then scales
// the c1 half by the Fp12 coefficient
// --------------------
`default_nettype none

module fe12_fmap
  import bls12_381_pkg::*;
(
  input  wire              i_clk,
  input  wire              i_rst,
  // Element input
  input  wire              i_val,
  output logic             o_rdy,
  input  wire              i_sop,
  input  wire              i_eop,
  input  fe_t              i_dat,
  input  wire [POW_W-1:0]  i_pow,
  // Element output
  output logic             o_val,
  input  wire              i_rdy,
  output logic             o_sop,
  output logic             o_eop,
  output fe_t              o_dat,
  // Link to the Fp6 stage
  output logic             o_f6_val,
  input  wire              i_f6_rdy,
  output logic             o_f6_sop,
  output logic             o_f6_eop,
  output fe_t              o_f6_dat,
  output logic [POW_W-1:0] o_f6_pow,
  input  wire              i_f6_val,
  output logic             o_f6_rdy,
  input  wire              i_f6_sop,
  input  wire              i_f6_eop,
  input  fe_t              i_f6_dat,
  input  wire [POW_W-1:0]  i_f6_pow,
  // Link to the Fp2 multiplier
  output logic             o_mul_val,
  input  wire              i_mul_rdy,
  output logic             o_mul_sop,
  output logic             o_mul_eop,
  output fe2_pair_t        o_mul_dat,
  output logic [POW_W-1:0] o_mul_pow,
  input  wire              i_mul_val,
  output logic             o_mul_rdy,
  input  wire              i_mul_sop,
  input  wire              i_mul_eop,
  input  fe_t              i_mul_dat
);

  logic [3:0] in_cnt, in_idx;     // Hop 1, beat 0..11
  logic [2:0] f6_cnt, f6_idx;     // Hop 2, beat within the Fp6 half
  logic       f6_half;            // Hop 2, 0 for c0 and 1 for c1
  logic [2:0] out_pair;           // Hop 3, Fp2 index 0..5
  fe_t        coef;

  always_comb begin
    o_rdy     = ~o_f6_val || i_f6_rdy;       // Skid-free ready rule
    o_f6_rdy  = ~o_mul_val || i_mul_rdy;
    o_mul_rdy = ~o_val || i_rdy;
    in_idx    = i_sop ? 4'd0 : in_cnt;
    f6_idx    = i_f6_sop ? 3'd0 : f6_cnt;
    if (!f6_half) coef = f6_idx[0] ? fe_t'(0) : fe_t'(1);
    else          coef = FROBENIUS_COEFF_FQ12_C1[i_f6_pow][f6_idx[0]];
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_f6_val  <= 1'b0;
      o_mul_val <= 1'b0;
      o_val     <= 1'b0;
      in_cnt    <= '0;
      f6_cnt    <= '0;
      f6_half   <= 1'b0;
      out_pair  <= '0;
    end else begin
      if (o_rdy) begin
        o_f6_val <= i_val;
        if (i_val) in_cnt <= (i_eop || in_idx == 4'd11) ? 4'd0 : in_idx + 4'd1;
      end
      if (o_f6_rdy) begin
        o_mul_val <= i_f6_val;
        if (i_f6_val) begin
          f6_cnt <= f6_idx + 3'd1;
          if (i_f6_eop) f6_half <= ~f6_half;  // Next Fp6 half
        end
      end
      if (o_mul_rdy) begin
        o_val <= i_mul_val;
        if (i_mul_val && i_mul_eop) out_pair <= (out_pair == 3'd5) ? 3'd0 : out_pair + 3'd1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_rdy) begin                          // Hop 1, Fp6 framing
      o_f6_sop <= in_idx == 4'd0 || in_idx == 4'd6;
      o_f6_eop <= in_idx == 4'd5 || in_idx == 4'd11;
      o_f6_dat <= i_dat;
      o_f6_pow <= i_pow;
    end
    if (o_f6_rdy) begin                       // Hop 2, operand pairs
      o_mul_sop <= ~f6_idx[0];
      o_mul_eop <= f6_idx[0];
      o_mul_dat <= {coef, i_f6_dat};
      o_mul_pow <= i_f6_pow;
    end
    if (o_mul_rdy) begin                      // Hop 3, Fp12 framing
      o_sop <= i_mul_sop && out_pair == 3'd0;
      o_eop <= i_mul_eop && out_pair == 3'd5;
      o_dat <= i_mul_dat;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fe6_fmap.sv ====
// --------------------
// Fp6 Frobenius stage
// Conjugates Fp2 parts for odd k, scales b1 and b2
// by the Fp6 coefficients through a local Fp2 multiplier
// --------------------
`default_nettype none

module fe6_fmap
  import bls12_381_pkg::*;
(
  input  wire              i_clk,
  input  wire              i_rst,
  input  wire              i_val,
  output logic             o_rdy,
  input  wire              i_sop,
  input  wire              i_eop,
  input  fe_t              i_dat,
  input  wire [POW_W-1:0]  i_pow,
  output logic             o_val,
  input  wire              i_rdy,
  output logic             o_sop,
  output logic             o_eop,
  output fe_t              o_dat,
  output logic [POW_W-1:0] o_pow
);

  logic [2:0]        in_cnt, in_idx;          // Beat 0..5 within the Fp6
  logic [1:0]        out_pair;                // Fp2 index 0..2 on the way out
  fe_t               dat_c, coef;
  logic              m_val, m_rdy, m_sop, m_eop;
  fe2_pair_t         m_dat;
  logic [POW_W-1:0]  m_pow;
  logic              p_val, p_rdy, p_sop, p_eop;
  fe_t               p_dat;
  logic [POW_W-1:0]  p_pow;

  always_comb begin
    in_idx = i_sop ? 3'd0 : in_cnt;           // Resync on each sop
    o_rdy  = ~m_val || m_rdy;
    p_rdy  = ~o_val || i_rdy;
    // Conjugate: negate the .c1 part when k is odd
    if (in_idx[0] && i_pow[0] && i_dat != '0) dat_c = P - i_dat;
    else                                      dat_c = i_dat;
    case (in_idx[2:1])
      2'd0:    coef = in_idx[0] ? fe_t'(0) : fe_t'(1);  // b0 times 1
      2'd1:    coef = FROBENIUS_COEFF_FQ6_C1[i_pow][in_idx[0]];
      default: coef = FROBENIUS_COEFF_FQ6_C2[i_pow][in_idx[0]];
    endcase
  end

  // Control of both hops
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      m_val    <= 1'b0;
      o_val    <= 1'b0;
      in_cnt   <= '0;
      out_pair <= '0;
    end else begin
      if (o_rdy) begin
        m_val <= i_val;
        if (i_val) in_cnt <= (i_eop || in_idx == 3'd5) ? 3'd0 : in_idx + 3'd1;
      end
      if (p_rdy) begin
        o_val <= p_val;
        if (p_val && p_eop) out_pair <= (out_pair == 2'd2) ? 2'd0 : out_pair + 2'd1;
      end
    end
  end

  // Payload and framing
  always_ff @(posedge i_clk) begin
    if (o_rdy) begin
      m_sop <= ~in_idx[0];
      m_eop <= in_idx[0];
      m_dat <= {coef, dat_c};
      m_pow <= i_pow;
    end
    if (p_rdy) begin
      o_sop <= p_sop && out_pair == 2'd0;     // Fp6 boundary every 6 beats
      o_eop <= p_eop && out_pair == 2'd2;
      o_dat <= p_dat;
      o_pow <= p_pow;
    end
  end

  fe2_mul #(
    .FE_TYPE (fe_t)
  ) u_fe2_mul (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (m_val),
    .o_rdy (m_rdy),
    .i_sop (m_sop),
    .i_eop (m_eop),
    .i_dat (m_dat),
    .i_pow (m_pow),
    .o_val (p_val),
    .i_rdy (p_rdy),
    .o_sop (p_sop),
    .o_eop (p_eop),
    .o_dat (p_dat),
    .o_pow (p_pow)
  );

endmodule

`default_nettype wire

// ==== hdl/fe2_mul.sv ====
// --------------------
// Fp2 modular multiplier
// Two-beat operand pairs in, two-beat products out, u^2 = -1
// --------------------
`default_nettype none

module fe2_mul
  import bls12_381_pkg::*;
#(
  parameter type FE_TYPE = fe_t
)(
  input  wire                           i_clk,
  input  wire                           i_rst,
  input  wire                           i_val,
  output logic                          o_rdy,
  input  wire                           i_sop,   // .c0 operand beat
  input  wire                           i_eop,   // .c1 operand beat
  input  wire [2*$bits(FE_TYPE)-1:0]    i_dat,   // {coefficient, data}
  input  wire [POW_W-1:0]               i_pow,
  output logic                          o_val,
  input  wire                           i_rdy,
  output logic                          o_sop,
  output logic                          o_eop,
  output FE_TYPE                        o_dat,
  output logic [POW_W-1:0]              o_pow
);

  localparam int W = $bits(FE_TYPE);

  logic [W-1:0]   a0, b0;                      // Held .c0 operands
  logic [2*W-1:0] m00, m11, m01, m10;          // Stage 1 full products
  logic [W-1:0]   r00, r11, r01, r10;          // Stage 2 reduced products
  logic [W-1:0]   re, im;                      // Stage 3 result
  logic [W-1:0]   im_hold;                     // Second output beat
  logic [W:0]     sub_c, add_c;
  logic [POW_W-1:0] pw1, pw2, pw3;
  logic v1, v2, v3;
  logic ser_free, adv1, adv2, adv3, fire;

  // Stall chain from the serializer back to the input
  always_comb begin
    ser_free = ~o_val || (i_rdy && o_eop);     // Empty or last beat leaving
    adv3     = v3 && ser_free;
    adv2     = v2 && (~v3 || adv3);
    adv1     = v1 && (~v2 || adv2);
    o_rdy    = ~v1 || adv1;
    fire     = i_val && o_rdy && i_eop;        // Full operand pair present
  end

  // Real part a0b0 - a1b1, imaginary part a0b1 + a1b0
  always_comb begin
    if (r00 >= r11) sub_c = {1'b0, r00} - r11;
    else            sub_c = {1'b0, r00} + P - r11;
    add_c = {1'b0, r01} + r10;
    if (add_c >= P) add_c = add_c - P;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      v1    <= 1'b0;
      v2    <= 1'b0;
      v3    <= 1'b0;
      o_val <= 1'b0;
      o_sop <= 1'b0;
      o_eop <= 1'b0;
    end else begin
      v1 <= fire ? 1'b1 : adv1 ? 1'b0 : v1;
      v2 <= adv1 ? 1'b1 : adv2 ? 1'b0 : v2;
      v3 <= adv2 ? 1'b1 : adv3 ? 1'b0 : v3;
      if (adv3) begin                          // Real part first
        o_val <= 1'b1;
        o_sop <= 1'b1;
        o_eop <= 1'b0;
      end else if (o_val && i_rdy) begin
        if (o_sop) begin
          o_sop <= 1'b0;                       // Move on to imaginary part
          o_eop <= 1'b1;
        end else begin
          o_val <= 1'b0;
        end
      end
    end
  end

  // Payload, no reset
  always_ff @(posedge i_clk) begin
    if (i_val && o_rdy && i_sop) begin
      a0 <= i_dat[W-1:0];
      b0 <= i_dat[2*W-1:W];
    end
    if (fire) begin
      m00 <= (2*W)'(a0) * (2*W)'(b0);
      m11 <= (2*W)'(i_dat[W-1:0]) * (2*W)'(i_dat[2*W-1:W]);
      m01 <= (2*W)'(a0) * (2*W)'(i_dat[2*W-1:W]);
      m10 <= (2*W)'(i_dat[W-1:0]) * (2*W)'(b0);
      pw1 <= i_pow;
    end
    if (adv1) begin                            // Direct reduction mod P
      r00 <= W'(m00 % (2*W)'(P));
      r11 <= W'(m11 % (2*W)'(P));
      r01 <= W'(m01 % (2*W)'(P));
      r10 <= W'(m10 % (2*W)'(P));
      pw2 <= pw1;
    end
    if (adv2) begin
      re  <= sub_c[W-1:0];
      im  <= add_c[W-1:0];
      pw3 <= pw2;
    end
    if (adv3) begin
      o_dat   <= re;
      im_hold <= im;
      o_pow   <= pw3;
    end else if (o_val && i_rdy && o_sop) begin
      o_dat <= im_hold;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/bls12_381_pkg.sv ====
// --------------------
// BLS12-381 field package
// Field element type, prime modulus, Frobenius
// coefficient tables and register map
// --------------------
`default_nettype none

package bls12_381_pkg;

  typedef logic [380:0] fe_t;            // One base-field element
  typedef logic [761:0] fe2_pair_t;      // {coefficient part, data part}

  parameter int POW_W = 2;               // Frobenius power field, k = 0..3

  // BLS12-381 prime
  parameter fe_t P = 381'h1a0111ea397fe69a4b1ba7b6434bacd764774b84f38512bf6730d2a0f6b0f6241eabfffeb153ffffb9feffffffffaaab;

  // Fp6 coefficients for b1, indexed [power][part]
  parameter fe_t FROBENIUS_COEFF_FQ6_C1 [4][2] = '{
    '{381'h1, 381'h0},
    '{381'h0,
      381'h1a0111ea397fe699ec02408663d4de85aa0d857d89759ad4897d29650fb85f9b409427eb4f49fffd8bfd00000000aaac},
    '{381'h00000000000000005f19672fdf76ce51ba69c6076a0f77eaddb3a93be6f89688de17d813620a00022e01fffffffefffe,
      381'h0},
    '{381'h0, 381'h1}
  };

  // Fp6 coefficients for b2
  parameter fe_t FROBENIUS_COEFF_FQ6_C2 [4][2] = '{
    '{381'h1, 381'h0},
    '{381'h1a0111ea397fe699ec02408663d4de85aa0d857d89759ad4897d29650fb85f9b409427eb4f49fffd8bfd00000000aaad,
      381'h0},
    '{381'h1a0111ea397fe699ec02408663d4de85aa0d857d89759ad4897d29650fb85f9b409427eb4f49fffd8bfd00000000aaac,
      381'h0},
    '{381'h1a0111ea397fe69a4b1ba7b6434bacd764774b84f38512bf6730d2a0f6b0f6241eabfffeb153ffffb9feffffffffaaaa,
      381'h0}
  };

  // Fp12 coefficients applied to the c1 half
  parameter fe_t FROBENIUS_COEFF_FQ12_C1 [4][2] = '{
    '{381'h1, 381'h0},
    '{381'h1904d3bf02bb0667c231beb4202c0d1f0fd603fd3cbd5f4f7b2443d784bab9c4f67ea53d63e7813d8d0775ed92235fb8,
      381'h00fc3e2b36c4e03288e9e902231f9fb854a14787b6c7b36fec0c8ec971f63c5f282d5ac14d6c7ec22cf78a126ddc4af3},
    '{381'h00000000000000005f19672fdf76ce51ba69c6076a0f77eaddb3a93be6f89688de17d813620a00022e01fffffffeffff,
      381'h0},
    '{381'h135203e60180a68ee2e9c448d77a2cd91c3dedd930b1cf60ef396489f61eb45e304466cf3e67fa0af1ee7b04121bdea2,
      381'h06af0e0437ff400b6831e36d6bd17ffe48395dabc2d3435e77f76e17009241c5ee67992f72ec05f4c81084fbede3cc09}
  };

  // APB register byte addresses
  parameter logic [7:0] REG_POWER  = 8'h00;  // RW, power k
  parameter logic [7:0] REG_STATUS = 8'h04;  // RO, bit 0 busy
  parameter logic [7:0] REG_COUNT  = 8'h08;  // RO, finished elements

endpackage

`default_nettype wire
